// ==== rtl/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// architectural word width
`define RV_XLEN 32

// data RAM size in 32-bit words
`define RV_DMEM_WORDS 256

// word address bits, log2 of the RAM depth
`define RV_DMEM_AW 8

`endif

// ==== rtl/rv_pipe_pkg.sv ====
`include "rv_macros.svh"

package rv_pipe_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_t;

    // same encoding as funct3 of loads and stores
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_type_t;

    typedef enum logic {
        CTRL_RUN,
        CTRL_HALTED
    } ctrl_state_t;

    // decoded operation entering execute, operands already read
    typedef struct packed {
        logic      valid;
        alu_op_t   alu_op;
        word_t     op_a;
        word_t     op_b;
        word_t     store_data;
        reg_idx_t  rd;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        mem_type_t mem_type;
        logic      ecall;
        word_t     pc;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_idx_t  rd;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        mem_type_t mem_type;
        word_t     result;      // alu result or effective address
        word_t     store_data;
        logic      ecall;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     reg_write;
        word_t    data;
        logic     ecall;
    } mem_wb_t;

endpackage

// ==== rtl/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import rv_pipe_pkg::*;
(
    input  id_ex_t  id_ex,
    output ex_mem_t ex_out
);

    word_t      alu_result;
    logic [4:0] shamt;

    // RV32I shifts only look at the low five bits
    assign shamt = id_ex.op_b[4:0];

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: begin
                alu_result = id_ex.op_a + id_ex.op_b;
            end
            ALU_SUB: begin
                alu_result = id_ex.op_a - id_ex.op_b;
            end
            ALU_AND: begin
                alu_result = id_ex.op_a & id_ex.op_b;
            end
            ALU_OR: begin
                alu_result = id_ex.op_a | id_ex.op_b;
            end
            ALU_XOR: begin
                alu_result = id_ex.op_a ^ id_ex.op_b;
            end
            ALU_SLL: begin
                alu_result = id_ex.op_a << shamt;
            end
            ALU_SRL: begin
                alu_result = id_ex.op_a >> shamt;
            end
            ALU_SRA: begin
                alu_result = word_t'($signed(id_ex.op_a) >>> shamt);
            end
            ALU_SLT: begin
                alu_result = word_t'($signed(id_ex.op_a) < $signed(id_ex.op_b));
            end
            ALU_SLTU: begin
                alu_result = word_t'(id_ex.op_a < id_ex.op_b);
            end
            ALU_PASS_B: begin
                // lui style, operand b already holds the immediate
                alu_result = id_ex.op_b;
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

    // loads and stores use the add result as effective address
    always_comb begin
        ex_out.valid      = id_ex.valid;
        ex_out.pc         = id_ex.pc;
        ex_out.rd         = id_ex.rd;
        ex_out.reg_write  = id_ex.reg_write;
        ex_out.mem_read   = id_ex.mem_read;
        ex_out.mem_write  = id_ex.mem_write;
        ex_out.mem_type   = id_ex.mem_type;
        ex_out.result     = alu_result;
        ex_out.store_data = id_ex.store_data;
        ex_out.ecall      = id_ex.ecall;
    end

endmodule

`default_nettype wire

// ==== rtl/ex_mem_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg
    import rv_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    advance,
    input  logic    flush,
    input  ex_mem_t ex_in,
    output ex_mem_t ex_mem
);

    ex_mem_t flushed;

    // a flushed slot keeps its payload but can no longer have side effects
    always_comb begin
        flushed           = ex_in;
        flushed.valid     = 1'b0;
        flushed.reg_write = 1'b0;
        flushed.mem_write = 1'b0;
        flushed.ecall     = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (advance) begin
            if (flush) begin
                ex_mem <= flushed;
            end else begin
                ex_mem <= ex_in;
            end
        end
        // otherwise hold for the stall
    end

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module mem_stage
    import rv_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    advance,
    input  ex_mem_t ex_mem,
    output mem_wb_t wb
);

    word_t                  dmem [`RV_DMEM_WORDS];
    logic [`RV_DMEM_AW-1:0] word_addr;
    logic [1:0]             byte_off;
    word_t                  rd_word;
    logic [7:0]             lane_byte;
    logic [15:0]            lane_half;
    word_t                  load_data;
    logic [3:0]             byte_en;
    word_t                  wr_data;
    logic                   wr_en;

    assign word_addr = ex_mem.result[`RV_DMEM_AW+1:2];
    assign byte_off  = ex_mem.result[1:0];
    assign rd_word   = dmem[word_addr];

    // store lanes, data replicated so every lane sees it
    always_comb begin
        case (ex_mem.mem_type)
            MEM_B, MEM_BU: begin
                byte_en = 4'b0001 << byte_off;
                wr_data = {4{ex_mem.store_data[7:0]}};
            end
            MEM_H, MEM_HU: begin
                byte_en = 4'b0011 << {byte_off[1], 1'b0};
                wr_data = {2{ex_mem.store_data[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wr_data = ex_mem.store_data;
            end
        endcase
    end

    assign wr_en = advance && ex_mem.valid && ex_mem.mem_write;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    dmem[word_addr][i*8 +: 8] <= wr_data[i*8 +: 8];
                end
            end
        end
    end

    // load lane select and extension
    assign lane_byte = rd_word[byte_off*8 +: 8];
    assign lane_half = rd_word[byte_off[1]*16 +: 16];

    always_comb begin
        case (ex_mem.mem_type)
            MEM_B:   load_data = {{(`RV_XLEN-8){lane_byte[7]}}, lane_byte};
            MEM_BU:  load_data = {{(`RV_XLEN-8){1'b0}}, lane_byte};
            MEM_H:   load_data = {{(`RV_XLEN-16){lane_half[15]}}, lane_half};
            MEM_HU:  load_data = {{(`RV_XLEN-16){1'b0}}, lane_half};
            default: load_data = rd_word;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else if (advance) begin
            wb.valid     <= ex_mem.valid;
            wb.pc        <= ex_mem.pc;
            wb.rd        <= ex_mem.rd;
            wb.reg_write <= ex_mem.reg_write;
            wb.data      <= ex_mem.mem_read ? load_data : ex_mem.result;
            wb.ecall     <= ex_mem.ecall;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pipe_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl
    import rv_pipe_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic stall,
    input  logic mem_ecall,
    output logic advance,
    output logic flush,
    output logic halted
);

    ctrl_state_t state;
    ctrl_state_t state_next;

    // everything moves unless the outside holds us
    assign advance = ~stall;

    always_comb begin
        state_next = state;
        case (state)
            CTRL_RUN: begin
                // halt only once the ecall has actually left the memory stage
                if (mem_ecall && advance) begin
                    state_next = CTRL_HALTED;
                end
            end
            CTRL_HALTED: begin
                state_next = CTRL_HALTED;
            end
            default: begin
                state_next = CTRL_RUN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CTRL_RUN;
        end else begin
            state <= state_next;
        end
    end

    assign halted = (state == CTRL_HALTED);

    // drop younger work from the moment the ecall is seen in memory
    assign flush = halted | mem_ecall;

endmodule

`default_nettype wire

// ==== rtl/rv_backend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_backend_top
    import rv_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,
    input  id_ex_t  id_ex,
    output mem_wb_t wb,
    output logic    halted
);

    ex_mem_t ex_out;
    ex_mem_t ex_mem;
    logic    advance;
    logic    flush;
    logic    mem_ecall;

    // only a valid ecall in the memory stage counts
    assign mem_ecall = ex_mem.valid & ex_mem.ecall;

    ex_stage ex_stage_i (
        .id_ex  (id_ex),
        .ex_out (ex_out)
    );

    ex_mem_reg ex_mem_reg_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .flush   (flush),
        .ex_in   (ex_out),
        .ex_mem  (ex_mem)
    );

    mem_stage mem_stage_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .ex_mem  (ex_mem),
        .wb      (wb)
    );

    pipe_ctrl pipe_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .mem_ecall (mem_ecall),
        .advance   (advance),
        .flush     (flush),
        .halted    (halted)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== bench/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker
    import rv_pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         stall,
    input  id_ex_t       id_ex,
    input  logic         exp_valid,
    input  logic [127:0] exp_name,
    input  mem_wb_t      exp_wb,
    input  mem_wb_t      wb,
    input  logic         halted,
    output int           pass_count,
    output int           fail_count,
    output int           pending
);

    logic [127:0] name_q[$];
    mem_wb_t      want_q[$];
    int           stamp_q[$];
    int           adv_count;
    logic         wb_new;
    logic         seen_issue;
    logic         reset_bad;
    int           passes;
    int           fails;

    assign pass_count = passes;
    assign fail_count = fails;

    // oldest outstanding issue against the writeback that just arrived
    task automatic check_writeback();
        logic [127:0] name;
        mem_wb_t      want;
        int           lat;
        if (name_q.size() == 0) begin
            $display("unexpected writeback from pc %h with nothing outstanding", wb.pc);
            fails++;
            return;
        end
        name = name_q.pop_front();
        want = want_q.pop_front();
        lat  = adv_count - stamp_q.pop_front();
        if (wb !== want) begin
            $write("ERR %0s expected pc=%h rd=%0d we=%b data=%h ecall=%b", name,
                   want.pc, want.rd, want.reg_write, want.data, want.ecall);
            $display(" actual pc=%h rd=%0d we=%b data=%h ecall=%b",
                     wb.pc, wb.rd, wb.reg_write, wb.data, wb.ecall);
            fails++;
        end else if (lat != 2) begin
            $display("%0s arrived %0d unstalled cycles after issue instead of 2", name, lat);
            fails++;
        end else if (want.ecall && !halted) begin
            $display("%0s was written back but halted stayed low", name);
            fails++;
        end else begin
            $display("%0s ok", name);
            passes++;
        end
    endtask

    // wb only changes after an unstalled edge
    always @(posedge clk) begin
        if (!rst_n) begin
            adv_count  = 0;
            wb_new     = 1'b0;
            seen_issue = 1'b0;
            reset_bad  = 1'b0;
        end else begin
            if (!seen_issue && !reset_bad && (wb !== '0 || halted !== 1'b0)) begin
                $display("reset_state: wb or halted not clear before the first issue");
                reset_bad = 1'b1;
                fails++;
            end
            if (wb_new && wb.valid) begin
                check_writeback();
            end
            if (!stall && id_ex.valid) begin
                if (!seen_issue && !reset_bad) begin
                    $display("reset_state ok");
                    passes++;
                end
                seen_issue = 1'b1;
                if (exp_valid) begin
                    name_q.push_back(exp_name);
                    want_q.push_back(exp_wb);
                    stamp_q.push_back(adv_count);
                end
            end
            if (!stall) begin
                adv_count++;
            end
            wb_new = !stall;
        end
        pending <= name_q.size();
    end

endmodule

// ==== bench/rv_backend_assertions.sv ====
`timescale 1ns/1ps

module rv_backend_assertions
    import rv_pipe_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    stall,
    input logic    halted,
    input ex_mem_t ex_mem,
    input mem_wb_t wb
);

    // the ecall itself is the last valid writeback
    wb_quiet_when_halted: assert property (
        @(posedge clk) disable iff (!rst_n) (halted && wb.valid) |-> wb.ecall
    ) else $error("writeback valid while halted");

    // a stalled edge leaves both pipeline registers and the halt state untouched
    regs_hold_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
            stall |=> ($stable(ex_mem) && $stable(wb) && $stable(halted))
    ) else $error("pipeline state changed during stall");

    // flush keeps every younger bundle out of EX/MEM once halted
    flush_when_halted: assert property (
        @(posedge clk) disable iff (!rst_n) halted |-> !ex_mem.valid
    ) else $error("valid bundle in EX/MEM while halted");

endmodule

bind rv_backend_top rv_backend_assertions assertions_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .stall   (stall),
    .halted  (halted),
    .ex_mem  (ex_mem),
    .wb      (wb)
);

// ==== bench/tb_top.sv ====
`timescale 1ns/1ps

module tb_top
    import rv_pipe_pkg::*;
();

    localparam int RESET_LIMIT  = 20;
    localparam int DRAIN_LIMIT  = 64;
    localparam int HALT_LIMIT   = 16;
    localparam int QUIET_CYCLES = 10;

    logic         clk;
    logic         rst_n;
    logic         stall;
    logic         halted;
    logic         exp_valid;
    logic [127:0] exp_name;
    id_ex_t       id_ex;
    mem_wb_t      wb;
    mem_wb_t      exp_wb;
    int           pass_count;
    int           fail_count;
    int           pending;
    int           seed;
    logic         ecall_sent;
    logic         run_broken;

    tb_clock_gen clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv_backend_top dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .id_ex  (id_ex),
        .wb     (wb),
        .halted (halted)
    );

    tb_checker checker_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .id_ex      (id_ex),
        .exp_valid  (exp_valid),
        .exp_name   (exp_name),
        .exp_wb     (exp_wb),
        .wb         (wb),
        .halted     (halted),
        .pass_count (pass_count),
        .fail_count (fail_count),
        .pending    (pending)
    );

    // one pattern line: idle gap, stall window holding the bundle, then issue
    task automatic issue_patterns();
        int           fd;
        int           fields;
        int           gap;
        int           stall_n;
        int           alu_n;
        int           rd_n;
        int           we;
        int           mr;
        int           mw;
        int           mt_n;
        int           ec;
        string        line;
        logic [127:0] name;
        word_t        a;
        word_t        b;
        word_t        sd;
        word_t        pc;
        word_t        data;
        id_ex_t       op;
        mem_wb_t      want;
        fd = $fopen("bench/rv_backend_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file");
            run_broken = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%s %d %d %h %h %h %d %d %d %d %d %d %h %h",
                             name, stall_n, alu_n, a, b, sd, rd_n, we, mr, mw,
                             mt_n, ec, pc, data);
            // comment and blank lines do not scan fully
            if (fields != 14) begin
                continue;
            end
            op            = '0;
            op.valid      = 1'b1;
            op.alu_op     = alu_op_t'(alu_n[3:0]);
            op.op_a       = a;
            op.op_b       = b;
            op.store_data = sd;
            op.rd         = rd_n[4:0];
            op.reg_write  = we[0];
            op.mem_read   = mr[0];
            op.mem_write  = mw[0];
            op.mem_type   = mem_type_t'(mt_n[2:0]);
            op.ecall      = ec[0];
            op.pc         = pc;
            want           = '0;
            want.valid     = 1'b1;
            want.pc        = pc;
            want.rd        = op.rd;
            want.reg_write = op.reg_write;
            want.data      = data;
            want.ecall     = op.ecall;
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge clk);
                id_ex <= '0;
                stall <= 1'b0;
            end
            repeat (stall_n) begin
                @(posedge clk);
                id_ex <= op;
                stall <= 1'b1;
            end
            @(posedge clk);
            id_ex     <= op;
            stall     <= 1'b0;
            exp_name  <= name;
            exp_wb    <= want;
            // anything issued behind an ecall is flushed
            exp_valid <= !ecall_sent;
            if (op.ecall) begin
                ecall_sent = 1'b1;
            end
        end
        $fclose(fd);
        @(posedge clk);
        id_ex <= '0;
        stall <= 1'b0;
    endtask

    initial begin
        int waited;
        seed       = 80;
        ecall_sent = 1'b0;
        run_broken = 1'b0;
        stall      = 1'b0;
        id_ex      = '0;
        exp_valid  = 1'b0;
        exp_name   = '0;
        exp_wb     = '0;
        waited = 0;
        while (!rst_n && waited < RESET_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!rst_n) begin
            $display("timeout: reset was never released");
            run_broken = 1'b1;
        end
        if (!run_broken) begin
            issue_patterns();
        end
        if (!run_broken) begin
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (pending != 0 && waited < DRAIN_LIMIT);
            if (pending != 0) begin
                $display("timeout: %0d writebacks never arrived", pending);
                run_broken = 1'b1;
            end
        end
        if (!run_broken && ecall_sent) begin
            waited = 0;
            while (!halted && waited < HALT_LIMIT) begin
                @(posedge clk);
                waited++;
            end
            if (!halted) begin
                $display("timeout: halted never rose after the ECALL");
                run_broken = 1'b1;
            end
        end
        // quiet window, the checker flags any late writeback
        if (!run_broken) begin
            repeat (QUIET_CYCLES) @(posedge clk);
        end
        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (run_broken || fail_count != 0) begin
            $display("RESULT: FAIL");
        end else begin
            $display("RESULT: PASS");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/rv_pipe_pkg.sv
rtl/ex_stage.sv
rtl/ex_mem_reg.sv
rtl/mem_stage.sv
rtl/pipe_ctrl.sv
rtl/rv_backend_top.sv
bench/tb_clock_gen.sv
bench/tb_checker.sv
bench/rv_backend_assertions.sv
bench/tb_top.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_top
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := RESULT: FAIL
PASS_MSG  := RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# an assertion stop leaves no pass line, so its absence also fails the run
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended early, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/rv_backend_patterns.txt ====
# name stall alu_op op_a op_b store_data rd reg_write mem_read mem_write mem_type ecall pc exp_data
# alu_op and mem_type are decimal enum codes, the other words are hex
alu_add   0 0  00000005 00000007 00000000 1  1 0 0 2 0 00000100 0000000c
alu_sub   1 1  00000005 00000007 00000000 2  1 0 0 2 0 00000104 fffffffe
alu_and   0 2  f0f0f0f0 ff00ff00 00000000 3  1 0 0 2 0 00000108 f000f000
alu_or    2 3  f0f0f0f0 0f0000ff 00000000 4  1 0 0 2 0 0000010c fff0f0ff
alu_xor   0 4  ffff0000 0ff00ff0 00000000 5  1 0 0 2 0 00000110 f00f0ff0
alu_sll   0 5  00000003 00000024 00000000 6  1 0 0 2 0 00000114 00000030
alu_srl   3 6  80000000 0000001f 00000000 7  1 0 0 2 0 00000118 00000001
alu_sra   0 7  80000010 00000004 00000000 8  1 0 0 2 0 0000011c f8000001
alu_slt   0 8  ffffffff 00000001 00000000 9  1 0 0 2 0 00000120 00000001
alu_sltu  1 9  ffffffff 00000001 00000000 10 1 0 0 2 0 00000124 00000000
alu_passb 0 10 00000000 12345000 00000000 11 1 0 0 2 0 00000128 12345000
st_word   0 0  00000040 00000000 8899aabb 0  0 0 1 2 0 0000012c 00000040
st_half   2 0  00000040 00000002 1234cafe 0  0 0 1 1 0 00000130 00000042
st_byte   0 0  00000040 00000001 0000007f 0  0 0 1 0 0 00000134 00000041
ld_word   1 0  00000040 00000000 00000000 6  1 1 0 2 0 00000138 cafe7fbb
ld_byte   0 0  00000040 00000000 00000000 7  1 1 0 0 0 0000013c ffffffbb
ld_ubyte  0 0  00000040 00000000 00000000 8  1 1 0 4 0 00000140 000000bb
ld_byte1  0 0  00000040 00000001 00000000 9  1 1 0 0 0 00000144 0000007f
ld_half   3 0  00000040 00000002 00000000 10 1 1 0 1 0 00000148 ffffcafe
ld_uhalf  0 0  00000040 00000002 00000000 11 1 1 0 5 0 0000014c 0000cafe
ecall     1 10 00000000 00000000 00000000 0  0 0 0 2 1 00000150 00000000
post_add  2 0  00000001 00000001 00000000 12 1 0 0 2 0 00000154 00000002
post_or   0 3  00000010 00000001 00000000 13 1 0 0 2 0 00000158 00000011
